// ==== common/sdramPkg.sv ====
// Shared definitions for the 68000 SDRAM controller and its memory model.
// Holds the x16 SDRAM geometry, the pin command encodings, the mode word
// and the structs that carry an access and a pin cycle between blocks.

package sdramPkg;

	//////////////////////////////
	// geometry
	//////////////////////////////

	localparam int BankWidth    = 2;	// four banks
	localparam int RowWidth     = 13;	// 8192 rows
	localparam int ColWidth     = 10;	// 1024 columns
	localparam int DataWidth    = 16;	// x16 part
	localparam int CpuAddrWidth = 32;	// full 68000 address bus as seen by the decoder

	localparam int CasLatency = 2;	// must agree with the latency field of ModeWord

	// burst length 1, sequential, CAS latency 2, single location writes
	localparam logic [RowWidth-1:0] ModeWord = 13'h0220;

	localparam int PrechargeAllBit = 10;	// A10 picks all banks or auto precharge

	//////////////////////////////
	// pin commands
	//////////////////////////////

	// one command word, read either as the raw code or as the five control pins
	typedef union packed {
		logic [4:0] raw;	// encoding as listed in the command table below
		struct packed {
			logic cke;	// clock enable, active high
			logic csL;	// chip select
			logic rasL;	// row strobe
			logic casL;	// column strobe
			logic weL;	// write enable
		} pin;
	} sdramCmdT;

	localparam sdramCmdT CmdPowerUp      = 5'b00000;	// CKE and CS held low while power settles
	localparam sdramCmdT CmdNop          = 5'b10111;
	localparam sdramCmdT CmdActivate     = 5'b10011;	// bank and row on the address pins
	localparam sdramCmdT CmdRead         = 5'b10101;	// A10 high gives auto precharge
	localparam sdramCmdT CmdWrite        = 5'b10100;	// A10 high gives auto precharge
	localparam sdramCmdT CmdPrechargeAll = 5'b10010;	// only with A10 high
	localparam sdramCmdT CmdAutoRefresh  = 5'b10001;
	localparam sdramCmdT CmdModeSet      = 5'b10000;	// mode word on the address pins

	//////////////////////////////
	// block to block payloads
	//////////////////////////////

	// one CPU access as captured by the bus port
	typedef struct packed {
		logic                 write;	// high for a 68000 write
		logic [BankWidth-1:0] bank;	// Address[25:24]
		logic [RowWidth-1:0]  row;	// Address[23:11]
		logic [ColWidth-1:0]  col;	// Address[10:1]
		logic [DataWidth-1:0] data;	// write word, full width since there is no byte mask
	} cpuReqT;

	// one pin cycle from the sequencer, registered onto the pins by the phy
	typedef struct packed {
		sdramCmdT             cmd;
		logic [BankWidth-1:0] bank;
		logic [RowWidth-1:0]  addr;
		logic                 writeEnable;	// drive write data in the same pin cycle
		logic                 readCapture;	// a read whose data comes back after the latency
	} sdramIssueT;

endpackage

// ==== sequencer/cycleTimer.sv ====
// Loadable down counter that stops at zero and flags it.
// The sequencer uses one for delays and one for the refresh interval.

module cycleTimer #(
	parameter int Width = 16
) (
	input  logic             Clock,
	input  logic             Reset_L,
	input  logic             load,	// take loadValue on the next edge
	input  logic [Width-1:0] loadValue,
	output logic             done	// high while the count sits at zero
);

	logic [Width-1:0] count;

	always_ff @(posedge Clock or negedge Reset_L) begin
		if (!Reset_L) begin
			count <= '0;
		end else if (load) begin
			count <= loadValue;
		end else if (count != '0) begin
			count <= count - 1'b1;	// hold at zero once expired
		end
	end

	assign done = (count == '0);

endmodule

// ==== sequencer/sdramSequencer.sv ====
// Control FSM of the controller. Runs the SDRAM power-up sequence while the
// CPU is kept in reset, then serves periodic refresh and single word accesses
// with auto precharge. Produces one pin cycle per clock on issue for the phy.

module sdramSequencer #(
	parameter int PowerUpCycles     = 5000,
	parameter int RefreshInterval   = 375,
	parameter int InitRefreshCycles = 39
) (
	input  logic                 Clock,
	input  logic                 Reset_L,
	input  logic                 req,	// access waiting in the bus port
	input  sdramPkg::cpuReqT     access,
	input  logic                 readValid,	// read word has been captured
	output logic                 ack,
	output sdramPkg::sdramIssueT issue,
	output logic                 cpuResetL	// releases the 68000 once init is over
);
	import sdramPkg::*;

	localparam int TimerWidth = 16;

	typedef enum logic [4:0] {
		sPowerUp, sPowerWait, sInitNop, sInitPrecharge, sInitArm, sInitRefresh,
		sInitGap, sModeSet, sModeGap, sIdle, sRefPrecharge, sRefNop, sRefresh,
		sRefGap, sActivate, sColumn, sReadWait, sAckWait
	} stateT;

	stateT state;
	stateT nextState;
	logic [1:0] gapCount;	// counts the three NOPs after refresh and mode set
	logic delayLoad;
	logic delayDone;
	logic refreshLoad;
	logic refreshDone;	// a refresh is due
	logic [TimerWidth-1:0] delayValue;

	//////////////////////////////
	// timers
	//////////////////////////////

	// power-up wait first, later the length of the init refresh loop
	assign delayValue = (state == sPowerUp) ? TimerWidth'(PowerUpCycles) :
		TimerWidth'(InitRefreshCycles);

	cycleTimer #(.Width(TimerWidth)) delayTimer (
		.Clock(Clock), .Reset_L(Reset_L), .load(delayLoad),
		.loadValue(delayValue), .done(delayDone)
	);

	cycleTimer #(.Width(TimerWidth)) refreshTimer (
		.Clock(Clock), .Reset_L(Reset_L), .load(refreshLoad),
		.loadValue(TimerWidth'(RefreshInterval)), .done(refreshDone)
	);

	//////////////////////////////
	// state and handshake
	//////////////////////////////

	always_ff @(posedge Clock or negedge Reset_L) begin
		if (!Reset_L) begin
			state     <= sPowerUp;
			gapCount  <= '0;
			ack       <= 1'b0;
			cpuResetL <= 1'b0;
		end else begin
			state <= nextState;
			if (state == sInitRefresh || state == sModeSet || state == sRefresh) begin
				gapCount <= 2'd2;	// gap state then lasts three clocks
			end else if (gapCount != '0) begin
				gapCount <= gapCount - 1'b1;
			end
			if ((state == sColumn && access.write) || (state == sReadWait && readValid)) begin
				ack <= 1'b1;	// a read already has its word in DataOut here
			end else if (state == sAckWait && !req) begin
				ack <= 1'b0;	// four-phase release
			end
			if (state == sModeGap && gapCount == '0) begin
				cpuResetL <= 1'b1;	// stays high until the next reset
			end
		end
	end

	//////////////////////////////
	// next state and pin cycle
	//////////////////////////////

	always_comb begin
		nextState   = state;
		issue       = '0;
		issue.cmd   = CmdNop;	// most cycles are NOPs
		delayLoad   = 1'b0;
		refreshLoad = 1'b0;
		case (state)
			sPowerUp: begin
				issue.cmd = CmdPowerUp;
				delayLoad = 1'b1;
				nextState = sPowerWait;
			end
			sPowerWait: begin
				issue.cmd = CmdPowerUp;	// CKE stays low for the whole wait
				if (delayDone) nextState = sInitNop;
			end
			sInitNop: nextState = sInitPrecharge;
			sInitPrecharge: begin
				issue.cmd = CmdPrechargeAll;
				issue.addr[PrechargeAllBit] = 1'b1;
				nextState = sInitArm;
			end
			sInitArm: begin
				delayLoad = 1'b1;	// refresh loop runs until this expires
				nextState = sInitRefresh;
			end
			sInitRefresh: begin
				issue.cmd = CmdAutoRefresh;
				nextState = sInitGap;
			end
			sInitGap: begin
				if (gapCount == '0) nextState = delayDone ? sModeSet : sInitRefresh;
			end
			sModeSet: begin
				issue.cmd  = CmdModeSet;
				issue.addr = ModeWord;
				nextState  = sModeGap;
			end
			sModeGap: begin
				if (gapCount == '0) begin
					refreshLoad = 1'b1;
					nextState   = sIdle;
				end
			end
			sIdle: begin
				if (refreshDone) nextState = sRefPrecharge;	// refresh wins over the CPU
				else if (req) nextState = sActivate;
			end
			sRefPrecharge: begin
				issue.cmd = CmdPrechargeAll;
				issue.addr[PrechargeAllBit] = 1'b1;
				nextState = sRefNop;
			end
			sRefNop: nextState = sRefresh;
			sRefresh: begin
				issue.cmd = CmdAutoRefresh;
				nextState = sRefGap;
			end
			sRefGap: begin
				if (gapCount == '0) begin
					refreshLoad = 1'b1;	// interval counts from the end of this refresh
					nextState   = sIdle;
				end
			end
			sActivate: begin
				issue.cmd  = CmdActivate;
				issue.bank = access.bank;
				issue.addr = access.row;
				nextState  = sColumn;
			end
			sColumn: begin
				issue.cmd  = access.write ? CmdWrite : CmdRead;
				issue.bank = access.bank;
				issue.addr[ColWidth-1:0] = access.col;
				issue.addr[PrechargeAllBit] = 1'b1;	// auto precharge closes the row
				issue.writeEnable = access.write;
				issue.readCapture = !access.write;
				nextState = access.write ? sAckWait : sReadWait;
			end
			sReadWait: begin
				if (readValid) nextState = sAckWait;
			end
			sAckWait: begin
				if (!req) nextState = sIdle;	// wait for AS_L to end the bus cycle
			end
			default: nextState = sPowerUp;
		endcase
	end

endmodule

// ==== source/cpuBusPort.sv ====
// CPU side of the controller. Qualifies a 68000 bus cycle aimed at the SDRAM,
// captures its address and write data, raises req towards the sequencer and
// turns the returned ack into Dtack_L. Read data is held on DataOut.

module cpuBusPort (
	input  logic                             Clock,
	input  logic                             Reset_L,
	input  logic [sdramPkg::CpuAddrWidth-1:0] Address,	// 68000 address bus
	input  logic [sdramPkg::DataWidth-1:0]   DataIn,	// 68000 write data
	input  logic                             UDS_L,	// upper data strobe
	input  logic                             LDS_L,	// lower data strobe
	input  logic                             WE_L,	// low for a write
	input  logic                             AS_L,	// address strobe
	input  logic                             DramSelect_L,	// address decoder hit
	input  logic                             ack,	// access finished in the sequencer
	input  logic                             readValid,	// read word arrives from the phy
	input  logic [sdramPkg::DataWidth-1:0]   readData,
	output logic                             req,
	output sdramPkg::cpuReqT                 access,
	output logic [sdramPkg::DataWidth-1:0]   DataOut,
	output logic                             Dtack_L
);
	import sdramPkg::*;

	logic qualified;	// a strobed access to the SDRAM is on the bus

	// both strobes only qualify the cycle because every write stores the whole word
	assign qualified = !AS_L && !DramSelect_L && (!UDS_L || !LDS_L);

	// req may only rise once the previous ack has been withdrawn
	always_ff @(posedge Clock or negedge Reset_L) begin
		if (!Reset_L) begin
			req <= 1'b0;
		end else if (!req) begin
			req <= qualified && !ack;	// start a new handshake
		end else begin
			req <= qualified;	// drop as soon as AS_L goes back high
		end
	end

	// address split and write data, frozen for the whole handshake
	always_ff @(posedge Clock) begin
		if (!req && qualified && !ack) begin
			access.write <= !WE_L;
			access.bank  <= Address[ColWidth+RowWidth+BankWidth:ColWidth+RowWidth+1];
			access.row   <= Address[ColWidth+RowWidth:ColWidth+1];
			access.col   <= Address[ColWidth:1];	// A0 is implied by the word bus
			access.data  <= DataIn;
		end
	end

	always_ff @(posedge Clock) begin
		if (readValid) begin
			DataOut <= readData;	// kept until the next read replaces it
		end
	end

	assign Dtack_L = !ack;	// low for exactly as long as the sequencer holds ack

endmodule

// ==== source/sdramPhy.sv ====
// Pin side of the controller. Registers each pin cycle from the sequencer onto
// the SDRAM pins, drives write data with its enable and captures read data.
// The DQ tristate buffer lives in the board top and uses sdramDqOutEnable.

module sdramPhy (
	input  logic                            Clock,
	input  logic                            Reset_L,
	input  sdramPkg::sdramIssueT            issue,
	input  logic [sdramPkg::DataWidth-1:0]  writeData,	// captured CPU word for writes
	input  logic [sdramPkg::DataWidth-1:0]  sdramDqIn,
	output logic                            sdramCke,
	output logic                            sdramCsL,
	output logic                            sdramRasL,
	output logic                            sdramCasL,
	output logic                            sdramWeL,
	output logic [sdramPkg::RowWidth-1:0]   sdramAddr,
	output logic [sdramPkg::BankWidth-1:0]  sdramBa,
	output logic [sdramPkg::DataWidth-1:0]  sdramDqOut,
	output logic                            sdramDqOutEnable,
	output logic                            readValid,	// one clock pulse per captured read
	output logic [sdramPkg::DataWidth-1:0]  readData
);
	import sdramPkg::*;

	logic [CasLatency-1:0] readPipe;	// one bit per read still in flight

	always_ff @(posedge Clock or negedge Reset_L) begin
		if (!Reset_L) begin
			sdramCke         <= CmdPowerUp.pin.cke;	// pins come out of reset powering up
			sdramCsL         <= CmdPowerUp.pin.csL;
			sdramRasL        <= CmdPowerUp.pin.rasL;
			sdramCasL        <= CmdPowerUp.pin.casL;
			sdramWeL         <= CmdPowerUp.pin.weL;
			sdramAddr        <= '0;
			sdramBa          <= '0;
			sdramDqOutEnable <= 1'b0;
			readPipe         <= '0;
			readValid        <= 1'b0;
		end else begin
			sdramCke         <= issue.cmd.pin.cke;
			sdramCsL         <= issue.cmd.pin.csL;
			sdramRasL        <= issue.cmd.pin.rasL;
			sdramCasL        <= issue.cmd.pin.casL;
			sdramWeL         <= issue.cmd.pin.weL;
			sdramAddr        <= issue.addr;
			sdramBa          <= issue.bank;
			sdramDqOutEnable <= issue.writeEnable;	// same pin cycle as the write command
			readPipe         <= {readPipe[CasLatency-2:0], issue.readCapture};
			readValid        <= readPipe[CasLatency-1];
		end
	end

	always_ff @(posedge Clock) begin
		sdramDqOut <= writeData;
		if (readPipe[CasLatency-1]) begin
			// sampled CasLatency edges after the read first shows on the pins
			readData <= sdramDqIn;
		end
	end

endmodule

// ==== source/m68kSdramCtrl.sv ====
// Top level of the 68000 to SDRAM controller. Sets the timing parameters and
// connects the bus port, the sequencer and the phy. The board top adds the
// DQ tristate from sdramDqOut, sdramDqOutEnable and sdramDqIn.

module m68kSdramCtrl #(
	parameter int PowerUpCycles     = 5000,	// 100 us at 50 MHz
	parameter int RefreshInterval   = 375,	// 7.5 us between auto refreshes
	parameter int InitRefreshCycles = 39	// clocks spent in the init refresh loop
) (
	input  logic                              Clock,
	input  logic                              Reset_L,
	input  logic [sdramPkg::CpuAddrWidth-1:0] Address,
	input  logic [sdramPkg::DataWidth-1:0]    DataIn,
	input  logic                              UDS_L,
	input  logic                              LDS_L,
	input  logic                              DramSelect_L,
	input  logic                              WE_L,
	input  logic                              AS_L,
	input  logic [sdramPkg::DataWidth-1:0]    sdramDqIn,
	output logic [sdramPkg::DataWidth-1:0]    DataOut,
	output logic                              Dtack_L,
	output logic                              ResetOut_L,	// 68000 reset, low during init
	output logic                              sdramCke,
	output logic                              sdramCsL,
	output logic                              sdramRasL,
	output logic                              sdramCasL,
	output logic                              sdramWeL,
	output logic [sdramPkg::RowWidth-1:0]     sdramAddr,
	output logic [sdramPkg::BankWidth-1:0]    sdramBa,
	output logic [sdramPkg::DataWidth-1:0]    sdramDqOut,
	output logic                              sdramDqOutEnable
);
	import sdramPkg::*;

	logic req;	// four-phase handshake between bus port and sequencer
	logic ack;
	cpuReqT access;
	sdramIssueT issue;	// next pin cycle
	logic readValid;
	logic [DataWidth-1:0] readData;

	cpuBusPort busPort (
		.Clock(Clock), .Reset_L(Reset_L), .Address(Address), .DataIn(DataIn),
		.UDS_L(UDS_L), .LDS_L(LDS_L), .WE_L(WE_L), .AS_L(AS_L),
		.DramSelect_L(DramSelect_L), .ack(ack), .readValid(readValid),
		.readData(readData), .req(req), .access(access), .DataOut(DataOut),
		.Dtack_L(Dtack_L)
	);

	sdramSequencer #(
		.PowerUpCycles(PowerUpCycles),
		.RefreshInterval(RefreshInterval),
		.InitRefreshCycles(InitRefreshCycles)
	) sequencer (
		.Clock(Clock), .Reset_L(Reset_L), .req(req), .access(access),
		.readValid(readValid), .ack(ack), .issue(issue), .cpuResetL(ResetOut_L)
	);

	// write data comes straight from the captured access which is stable until ack drops
	sdramPhy phy (
		.Clock(Clock), .Reset_L(Reset_L), .issue(issue), .writeData(access.data),
		.sdramDqIn(sdramDqIn), .sdramCke(sdramCke), .sdramCsL(sdramCsL),
		.sdramRasL(sdramRasL), .sdramCasL(sdramCasL), .sdramWeL(sdramWeL),
		.sdramAddr(sdramAddr), .sdramBa(sdramBa), .sdramDqOut(sdramDqOut),
		.sdramDqOutEnable(sdramDqOutEnable), .readValid(readValid),
		.readData(readData)
	);

endmodule

// ==== verif/sdramModel.sv ====
// Behavioral x16 SDRAM for the controller testbench. Decodes the pin commands,
// stores written words, returns read words and flags illegal command sequences.
// initDone rises once the power-up sequence has been seen in the right order.

module sdramModel #(
	parameter int PowerUpCycles = 5000
) (
	input  logic                           Clock,
	input  logic                           Reset_L,
	input  logic                           cke,
	input  logic                           csL,
	input  logic                           rasL,
	input  logic                           casL,
	input  logic                           weL,
	input  logic [sdramPkg::RowWidth-1:0]  addr,
	input  logic [sdramPkg::BankWidth-1:0] ba,
	input  logic [sdramPkg::DataWidth-1:0] dqOut,
	input  logic                           dqOutEnable,
	output logic [sdramPkg::DataWidth-1:0] dqIn,
	output logic                           initDone,	// power-up sequence complete and legal
	output logic                           modelError	// sticky, set by any illegal command
);
	timeunit 1ns;
	timeprecision 100ps;
	import sdramPkg::*;

	// write burst single, standard operation, CAS latency 2, sequential, burst length 1
	localparam logic [RowWidth-1:0] ExpectedMode = {3'b000, 1'b1, 2'b00, 3'd2, 1'b0, 3'b000};

	logic [DataWidth-1:0] mem [logic [BankWidth+RowWidth+ColWidth-1:0]];	// sparse storage
	logic [RowWidth-1:0] openRow [4];	// row latched by the last activate per bank
	logic [3:0] bankOpen;
	logic [BankWidth-1:0] lastActBank;	// a column command must follow this activate
	logic [4:0] cmdRaw;
	logic [BankWidth+RowWidth+ColWidth-1:0] key;
	logic [1:0] initStep;	// 0 cke low, 1 wait for precharge, 2 refresh loop, 3 done
	int ckeLowCount;
	int initRefreshes;

	assign cmdRaw = {cke, csL, rasL, casL, weL};
	assign key = {ba, openRow[ba], addr[ColWidth-1:0]};
	assign initDone = (initStep == 2'd3);

	task automatic flagIllegal(input string what);
		$display("sdramModel: %s at %0t ns", what, $time);
		modelError <= 1'b1;
	endtask

	always @(posedge Clock or negedge Reset_L) begin
		if (!Reset_L) begin
			bankOpen      <= '0;
			lastActBank   <= '0;
			initStep      <= '0;
			ckeLowCount   <= 0;
			initRefreshes <= 0;
			modelError    <= 1'b0;
			dqIn          <= '0;
		end else begin
			//////////////////////////////
			// command decode
			//////////////////////////////
			dqIn <= '0;	// a read word sits on DQ for a single clock only
			if (cmdRaw == CmdActivate.raw) begin
				assert (!bankOpen[ba]) else flagIllegal("activate to a bank that is still open");
				bankOpen[ba] <= 1'b1;
				openRow[ba]  <= addr;
				lastActBank  <= ba;
			end else if (cmdRaw == CmdRead.raw || cmdRaw == CmdWrite.raw) begin
				assert (bankOpen[ba] && ba == lastActBank)
					else flagIllegal("column command to a bank that was not just activated");
				assert (addr[PrechargeAllBit]) else flagIllegal("column command without A10");
				if (cmdRaw == CmdWrite.raw) begin
					assert (dqOutEnable) else flagIllegal("write with DQ not driven");
					mem[key] = dqOut;	// full word, there is no byte mask
				end else begin
					assert (!dqOutEnable) else flagIllegal("read while the controller drives DQ");
					// returned one clock after the read is sampled, where the phy picks it up
					dqIn <= mem.exists(key) ? mem[key] : '0;
				end
				bankOpen[ba] <= 1'b0;	// auto precharge closes the row
			end else if (cmdRaw == CmdPrechargeAll.raw) begin
				assert (addr[PrechargeAllBit]) else flagIllegal("precharge with A10 low");
				bankOpen <= '0;
			end else if (cmdRaw == CmdAutoRefresh.raw) begin
				assert (bankOpen == '0) else flagIllegal("auto refresh with a bank open");
			end

			//////////////////////////////
			// power-up order
			//////////////////////////////
			case (initStep)
				2'd0: begin
					if (!cke) begin
						ckeLowCount <= ckeLowCount + 1;
					end else begin
						assert (ckeLowCount >= PowerUpCycles && cmdRaw == CmdNop.raw)
							else flagIllegal("power-up wait too short or not ended by a NOP");
						initStep <= 2'd1;
					end
				end
				2'd1: begin
					if (cmdRaw == CmdPrechargeAll.raw && addr[PrechargeAllBit]) begin
						initStep <= 2'd2;
					end else begin
						assert (cmdRaw == CmdNop.raw)
							else flagIllegal("power-up not followed by precharge-all");
					end
				end
				2'd2: begin
					if (cmdRaw == CmdAutoRefresh.raw) begin
						initRefreshes <= initRefreshes + 1;
					end else if (cmdRaw == CmdModeSet.raw) begin
						assert (initRefreshes >= 2 && addr == ExpectedMode)
							else flagIllegal("mode set too early or with a wrong mode word");
						initStep <= 2'd3;
					end else begin
						assert (cmdRaw == CmdNop.raw)
							else flagIllegal("unexpected command in the init refresh loop");
					end
				end
				default: ;	// init over, only the decode checks apply
			endcase
		end
	end

endmodule

// ==== verif/tbM68kSdramCtrl.sv ====
// Testbench for the 68000 SDRAM controller. Runs the DUT with short timing
// parameters against the behavioral SDRAM and checks init order, refresh
// spacing, write/read data, address mapping and the Dtack handshake.

module tbM68kSdramCtrl;
	timeunit 1ns;
	timeprecision 100ps;
	import sdramPkg::*;

	localparam int PowerUpCycles     = 8;
	localparam int RefreshInterval   = 60;
	localparam int InitRefreshCycles = 10;
	localparam int ClockPeriod       = 20;
	localparam int InputDelay        = 2;	// inputs change this long after the rising edge
	localparam int AccessLimit       = 40;	// one access with a refresh in front of it fits
	localparam int RefreshLimit      = RefreshInterval + 12;
	localparam int NumRandom         = 48;
	localparam int InitCycles        = 10 + PowerUpCycles + 5 * InitRefreshCycles + 50;
	localparam int WatchdogCycles    = 200 * AccessLimit + InitCycles;

	logic Clock = 1'b0;
	logic Reset_L;
	logic [CpuAddrWidth-1:0] Address;
	logic [DataWidth-1:0] DataIn;
	logic UDS_L, LDS_L, DramSelect_L, WE_L, AS_L;
	logic [DataWidth-1:0] DataOut;
	logic Dtack_L, ResetOut_L;
	logic sdramCke, sdramCsL, sdramRasL, sdramCasL, sdramWeL;
	logic [RowWidth-1:0] sdramAddr;
	logic [BankWidth-1:0] sdramBa;
	logic [DataWidth-1:0] sdramDqOut, sdramDqIn;
	logic sdramDqOutEnable;
	logic initDone, modelError;
	logic [4:0] pinCmd;	// command on the pins, stable around the falling edge
	logic [DataWidth-1:0] scoreboard [logic [CpuAddrWidth-1:0]];
	logic [CpuAddrWidth-1:0] addrList [$];

	assign pinCmd = {sdramCke, sdramCsL, sdramRasL, sdramCasL, sdramWeL};

	always #(ClockPeriod / 2) Clock = ~Clock;

	m68kSdramCtrl #(
		.PowerUpCycles(PowerUpCycles),
		.RefreshInterval(RefreshInterval),
		.InitRefreshCycles(InitRefreshCycles)
	) dut (.*);

	sdramModel #(.PowerUpCycles(PowerUpCycles)) model (
		.Clock(Clock), .Reset_L(Reset_L), .cke(sdramCke), .csL(sdramCsL),
		.rasL(sdramRasL), .casL(sdramCasL), .weL(sdramWeL), .addr(sdramAddr),
		.ba(sdramBa), .dqOut(sdramDqOut), .dqOutEnable(sdramDqOutEnable),
		.dqIn(sdramDqIn), .initDone(initDone), .modelError(modelError)
	);

	//////////////////////////////
	// error reporting
	//////////////////////////////

	task automatic valueMismatch(input string test, input logic [31:0] expected,
		input logic [31:0] actual);
		$display("[FAIL] %s: expected %0h, actual %0h", test, expected, actual);
		$display("Simulation finished: FAIL");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic fatalError(input string what);
		$display("ERROR: %s at %0t ns", what, $time);
		$display("Simulation finished: FAIL");
		$fatal(1, "stopped at the first error");
	endtask

	// location the model should use, from the bank/row/column split of the address
	function automatic logic [BankWidth+RowWidth+ColWidth-1:0] modelLocation(
		input logic [CpuAddrWidth-1:0] addr);
		return {addr[25:24], addr[23:11], addr[10:1]};
	endfunction

	//////////////////////////////
	// bus cycles
	//////////////////////////////

	task automatic driveStrobes(input logic active);
		AS_L         = !active;
		UDS_L        = !active;
		LDS_L        = !active;
		DramSelect_L = !active;
	endtask

	task automatic runCycle(input logic [CpuAddrWidth-1:0] addr, input logic write,
		input logic [DataWidth-1:0] wdata, output logic [DataWidth-1:0] rdata);
		int waited;
		@(posedge Clock);
		#InputDelay;
		Address = addr;
		DataIn  = wdata;
		WE_L    = !write;
		driveStrobes(1'b1);
		waited = 0;
		do begin
			@(negedge Clock);
			waited++;
			assert (waited <= AccessLimit) else fatalError("Dtack_L never fell for an access");
		end while (Dtack_L);
		rdata = DataOut;	// DataOut is loaded in the same clock that ack rises
		repeat (2) begin
			@(negedge Clock);
			assert (!Dtack_L) else valueMismatch("dtack hold while AS_L low", 0, 32'(Dtack_L));
		end
		@(posedge Clock);
		#InputDelay;
		driveStrobes(1'b0);
		WE_L = 1'b1;
		waited = 0;
		do begin
			@(negedge Clock);
			waited++;
			assert (waited <= 4) else fatalError("Dtack_L stayed low after AS_L rose");
		end while (!Dtack_L);
	endtask

	task automatic writeWord(input logic [CpuAddrWidth-1:0] addr, input logic [DataWidth-1:0] data);
		logic [DataWidth-1:0] unused;
		runCycle(addr, 1'b1, data, unused);
		scoreboard[addr] = data;
	endtask

	task automatic readWord(input logic [CpuAddrWidth-1:0] addr, output logic [DataWidth-1:0] data);
		runCycle(addr, 1'b0, '0, data);
	endtask

	// waits for the next auto refresh on the pins and checks how long it took
	task automatic awaitRefresh(input string test);
		int gap;
		gap = 0;
		do begin
			@(negedge Clock);
			gap++;
		end while (pinCmd != CmdAutoRefresh.raw && gap <= RefreshLimit);
		assert (gap <= RefreshLimit) else valueMismatch(test, RefreshLimit, gap);
	endtask

	//////////////////////////////
	// monitors
	//////////////////////////////

	always @(negedge Clock) begin
		if (Reset_L) begin
			assert (!modelError) else fatalError("memory model saw an illegal command");
			if (!ResetOut_L) begin
				assert (Dtack_L) else valueMismatch("no access during init", 1, 32'(Dtack_L));
			end else begin
				assert (initDone) else valueMismatch("init order", 1, 32'(initDone));
			end
			if (!Dtack_L || !ResetOut_L) begin
				assert (pinCmd != CmdActivate.raw)
					else fatalError("activate issued while Dtack_L low or CPU in reset");
			end
		end
	end

	initial begin
		#(WatchdogCycles * ClockPeriod);
		fatalError("watchdog expired before the tests finished");
	end

	//////////////////////////////
	// test sequence
	//////////////////////////////

	initial begin
		logic [DataWidth-1:0] readBack;
		logic [DataWidth-1:0] data;
		logic [CpuAddrWidth-1:0] addr;
		logic [BankWidth+RowWidth+ColWidth-1:0] loc;
		int waited;
		void'($urandom(32'h3ec3));
		Reset_L = 1'b0;
		Address = '0;
		DataIn  = '0;
		WE_L    = 1'b1;
		driveStrobes(1'b0);
		repeat (10) @(posedge Clock);
		#InputDelay;
		Reset_L = 1'b1;

		// a CPU cycle during init must see neither Dtack nor an activate
		driveStrobes(1'b1);
		repeat (6) @(posedge Clock);
		#InputDelay;
		driveStrobes(1'b0);
		waited = 0;
		do begin
			@(negedge Clock);
			waited++;
			assert (waited <= InitCycles) else fatalError("ResetOut_L never released");
		end while (!ResetOut_L);
		assert (initDone) else valueMismatch("init order", 1, 32'(initDone));

		// idle bus, refreshes must keep coming
		awaitRefresh("first refresh after init");
		repeat (3) awaitRefresh("refresh interval");

		writeWord(32'h0000_0100, 16'hA55A);
		readWord(32'h0000_0100, readBack);
		assert (readBack == 16'hA55A) else valueMismatch("write then read", 16'hA55A, 32'(readBack));

		// spread over all banks, the model location is predicted from the address split
		for (int i = 0; i < NumRandom; i++) begin
			addr = ($urandom & 32'h00FF_FFFE) | (32'(i % 4) << 24);
			data = 16'($urandom);
			writeWord(addr, data);
			addrList.push_back(addr);
			loc = modelLocation(addr);
			assert (model.mem[loc] == scoreboard[addr])
				else valueMismatch("model location", 32'(scoreboard[addr]), 32'(model.mem[loc]));
		end
		foreach (addrList[i]) begin
			readWord(addrList[i], readBack);
			assert (readBack == scoreboard[addrList[i]])
				else valueMismatch("address mapping", 32'(scoreboard[addrList[i]]), 32'(readBack));
		end

		if (modelError) begin
			fatalError("memory model flagged an illegal command");
		end else begin
			$display("Simulation finished: PASS");
			$finish;
		end
	end

endmodule

// ==== m68kSdramCtrl.f ====
common/sdramPkg.sv
sequencer/cycleTimer.sv
sequencer/sdramSequencer.sv
source/cpuBusPort.sv
source/sdramPhy.sv
source/m68kSdramCtrl.sv
verif/sdramModel.sv
verif/tbM68kSdramCtrl.sv

// ==== runSim.sh ====
#!/bin/sh
# Builds the controller testbench with Verilator and runs it.
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module tbM68kSdramCtrl -f m68kSdramCtrl.f --Mdir obj_dir -o simv
output=$(./obj_dir/simv 2>&1) || true
echo "$output"
echo "$output" | grep -q "Simulation finished: PASS"
